//--- include/p2p_config.svh
`ifndef P2P_CONFIG_SVH
`define P2P_CONFIG_SVH

// ***************************************************************************
// datapath widths
// ***************************************************************************
`define P2P_DATA_W      64  // one beat, 8 bytes
`define P2P_DHEAD_W     64  // packet head

// ***************************************************************************
// payload buffer geometry
// ***************************************************************************
`define BUF_ADDR_WIDTH  6   // 64 blocks
`define PBUF_SZ_LOG     5   // 32-byte blocks, 4 beats each

// descriptor fields
`define DEV_NUM_WIDTH   8
`define MSG_BLEN_WIDTH  16

// queue depths
`define DESC_FIFO_LOG   2   // 4 descriptors
`define ADDR_FIFO_LOG   4   // 16 block addresses

`endif

//--- hdl/p2p_pkg.sv
`include "p2p_config.svh"

package p2p_pkg;

    // ***********************************************************************
    // plain vectors
    // ***********************************************************************
    typedef logic [`P2P_DATA_W-1:0]      beat_data_t;  // one payload beat
    typedef logic [`P2P_DHEAD_W-1:0]     p2p_head_t;   // ddev 47:40, sdev 39:32, blen 15:0
    typedef logic [`BUF_ADDR_WIDTH-1:0]  buf_addr_t;   // block number
    typedef logic [`PBUF_SZ_LOG-4:0]     buf_off_t;    // beat within block
    typedef logic [`DEV_NUM_WIDTH-1:0]   dev_num_t;
    typedef logic [`MSG_BLEN_WIDTH-1:0]  blen_t;       // bytes, 1 to 512

    // ***********************************************************************
    // bundles
    // ***********************************************************************
    typedef struct packed {
        logic [47:0] dlid;   // dest local id, carried only
        dev_num_t    ddev;
        dev_num_t    sdev;
        blen_t       blen;
    } p2p_desc_t;

    typedef struct packed {
        p2p_desc_t desc;     // head descriptor
        buf_addr_t addr;     // current block of that descriptor
        logic      last;     // final block of the list
    } qstruct_t;

    typedef struct packed {
        buf_addr_t addr;
        buf_off_t  offset;
        p2p_head_t head;
        logic      last;     // last beat of the packet
    } pbuf_req_t;

    typedef struct packed {
        buf_addr_t  addr;
        buf_off_t   offset;
        beat_data_t data;
    } pbuf_wr_t;

    typedef struct packed {
        logic       last;
        p2p_head_t  head;    // meaningful on first beat
        beat_data_t data;
    } p2p_beat_t;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        DESC_PARSE = 2'd1,   // issuing read requests
        DRAIN      = 2'd2    // waiting for the last beat downstream
    } send_state_e;

endpackage

//--- hdl/tgt_qstruct_queue.sv
`include "p2p_config.svh"

module tgt_qstruct_queue (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                desc_valid,
    input  p2p_pkg::p2p_desc_t  desc,
    output logic                desc_ready,

    input  logic                baddr_valid,
    input  p2p_pkg::buf_addr_t  baddr,
    input  logic                baddr_last,
    output logic                baddr_ready,

    output logic                qstruct_valid,
    output p2p_pkg::qstruct_t   qstruct,
    input  logic                qstruct_ready,
    input  p2p_pkg::buf_off_t   qstruct_offset
);
    import p2p_pkg::*;

    localparam int DESC_DEPTH = 1 << `DESC_FIFO_LOG;
    localparam int ADDR_DEPTH = 1 << `ADDR_FIFO_LOG;

    // ***********************************************************************
    // storage
    // ***********************************************************************
    p2p_desc_t desc_mem      [DESC_DEPTH];
    buf_addr_t addr_mem      [ADDR_DEPTH];
    logic      addr_last_mem [ADDR_DEPTH];

    logic [`DESC_FIFO_LOG-1:0] desc_wr_ptr, desc_rd_ptr;
    logic [`DESC_FIFO_LOG:0]   desc_cnt;             // one extra bit for full
    logic [`ADDR_FIFO_LOG-1:0] addr_wr_ptr, addr_rd_ptr;
    logic [`ADDR_FIFO_LOG:0]   addr_cnt;

    logic desc_push, desc_pop;
    logic addr_push, addr_pop;

    assign desc_ready  = ~desc_cnt[`DESC_FIFO_LOG];  // full when msb set
    assign baddr_ready = ~addr_cnt[`ADDR_FIFO_LOG];

    assign desc_push = desc_valid & desc_ready;
    assign addr_push = baddr_valid & baddr_ready;

    // block done on offset 3 or the short final block
    assign addr_pop = qstruct_valid & qstruct_ready &
                      ((&qstruct_offset) | qstruct.last);
    assign desc_pop = addr_pop & qstruct.last;      // leaves with its last block

    // head of both fifos
    assign qstruct_valid = (|desc_cnt) & (|addr_cnt);
    assign qstruct.desc  = desc_mem[desc_rd_ptr];
    assign qstruct.addr  = addr_mem[addr_rd_ptr];
    assign qstruct.last  = addr_last_mem[addr_rd_ptr];

    always_ff @(posedge clk) begin
        if (desc_push) begin
            desc_mem[desc_wr_ptr] <= desc;
        end
        if (addr_push) begin
            addr_mem[addr_wr_ptr]      <= baddr;
            addr_last_mem[addr_wr_ptr] <= baddr_last;
        end
    end

    // ***********************************************************************
    // pointers and counts
    // ***********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            desc_wr_ptr <= '0;
            desc_rd_ptr <= '0;
            desc_cnt    <= '0;
        end else begin
            if (desc_push) desc_wr_ptr <= desc_wr_ptr + 1'b1;  // wraps
            if (desc_pop)  desc_rd_ptr <= desc_rd_ptr + 1'b1;
            case ({desc_push, desc_pop})
                2'b10:   desc_cnt <= desc_cnt + 1'b1;
                2'b01:   desc_cnt <= desc_cnt - 1'b1;
                default: desc_cnt <= desc_cnt;             // none or both
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_wr_ptr <= '0;
            addr_rd_ptr <= '0;
            addr_cnt    <= '0;
        end else begin
            if (addr_push) addr_wr_ptr <= addr_wr_ptr + 1'b1;
            if (addr_pop)  addr_rd_ptr <= addr_rd_ptr + 1'b1;
            case ({addr_push, addr_pop})
                2'b10:   addr_cnt <= addr_cnt + 1'b1;
                2'b01:   addr_cnt <= addr_cnt - 1'b1;
                default: addr_cnt <= addr_cnt;
            endcase
        end
    end

endmodule

//--- hdl/pyld_buf.sv
`include "p2p_config.svh"

module pyld_buf (
    input  logic                clk,
    input  logic                rst_n,

    // fill port from the writer
    input  logic                pbuf_wr_en,
    input  p2p_pkg::pbuf_wr_t   pbuf_wr,

    // read requests from the send processor
    input  logic                pbuf_free_valid,
    input  p2p_pkg::pbuf_req_t  pbuf_free,
    output logic                pbuf_free_ready,

    // payload beats out
    output logic                ft_pyld_valid,
    output p2p_pkg::p2p_beat_t  ft_pyld,
    input  logic                ft_pyld_ready
);
    import p2p_pkg::*;

    localparam int OFF_W   = `PBUF_SZ_LOG - 3;            // beats per block, log
    localparam int IDX_W   = `BUF_ADDR_WIDTH + OFF_W;     // beat index width
    localparam int N_BEATS = 1 << IDX_W;                  // 256

    // ***********************************************************************
    // beat memory, block-major
    // ***********************************************************************
    beat_data_t mem [N_BEATS];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             rd_fire;

    assign wr_idx = {pbuf_wr.addr, pbuf_wr.offset};       // block then offset
    assign rd_idx = {pbuf_free.addr, pbuf_free.offset};

    always_ff @(posedge clk) begin
        if (pbuf_wr_en) begin
            mem[wr_idx] <= pbuf_wr.data;
        end
    end

    // ***********************************************************************
    // output register
    // ***********************************************************************
    // full rate as long as downstream keeps taking
    assign pbuf_free_ready = ~ft_pyld_valid | ft_pyld_ready;
    assign rd_fire         = pbuf_free_valid & pbuf_free_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ft_pyld_valid <= 1'b0;
        end else if (rd_fire) begin
            ft_pyld_valid <= 1'b1;                         // refill or hold
        end else if (ft_pyld_ready) begin
            ft_pyld_valid <= 1'b0;                         // drained
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            ft_pyld.data <= mem[rd_idx];
            ft_pyld.head <= pbuf_free.head;                // rides along with the beat
            ft_pyld.last <= pbuf_free.last;
        end
    end

endmodule

//--- hdl/tgt_pyld_send_proc.sv
`include "p2p_config.svh"

module tgt_pyld_send_proc (
    input  logic                clk,
    input  logic                rst_n,

    // head of the descriptor queue
    input  logic                qstruct_valid,
    input  p2p_pkg::qstruct_t   qstruct,
    output logic                qstruct_ready,
    output p2p_pkg::buf_off_t   qstruct_offset,

    // read requests to the payload buffer
    output logic                pbuf_free_valid,
    output p2p_pkg::pbuf_req_t  pbuf_free,
    input  logic                pbuf_free_ready,

    // observed only, marks packet end
    input  logic                ft_pyld_valid,
    input  logic                ft_pyld_last,
    input  logic                ft_pyld_ready
);
    import p2p_pkg::*;

    localparam int BEAT_LOG = $clog2(`P2P_DATA_W / 8);    // 3, bytes per beat

    send_state_e cur_state, nxt_state;

    buf_off_t ft_offset;       // beat within current block
    buf_off_t last_offset;     // offset of final beat in last block
    blen_t    blen_m1;
    logic     is_desc_parse;
    logic     req_fire;
    logic     req_last;
    logic     pyld_last_fire;

    // ***********************************************************************
    // descriptor decode
    // ***********************************************************************
    assign blen_m1     = qstruct.desc.blen - 1'b1;
    assign last_offset = blen_m1[`PBUF_SZ_LOG-1:BEAT_LOG];  // ((blen-1)/8) mod 4

    assign is_desc_parse  = (cur_state == DESC_PARSE);
    assign req_last       = qstruct.last & (ft_offset == last_offset);
    assign req_fire       = pbuf_free_valid & pbuf_free_ready;
    assign pyld_last_fire = ft_pyld_valid & ft_pyld_ready & ft_pyld_last;

    // ***********************************************************************
    // request out
    // ***********************************************************************
    assign pbuf_free_valid = qstruct_valid & is_desc_parse;
    assign qstruct_ready   = req_fire & ((&ft_offset) | req_last);  // block done
    assign qstruct_offset  = ft_offset;

    always_comb begin
        pbuf_free.addr   = qstruct.addr;
        pbuf_free.offset = ft_offset;
        pbuf_free.last   = req_last;
        pbuf_free.head   = {{(`P2P_DHEAD_W - 32 - 2 * `DEV_NUM_WIDTH){1'b0}},
                            qstruct.desc.ddev,               // 47:40
                            qstruct.desc.sdev,               // 39:32
                            {(32 - `MSG_BLEN_WIDTH){1'b0}},  // reserved
                            qstruct.desc.blen};              // 15:0
    end

    // beat offset, wraps past 3, back to 0 at packet end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ft_offset <= '0;
        end else if (req_fire & req_last) begin
            ft_offset <= '0;
        end else if (req_fire) begin
            ft_offset <= ft_offset + 1'b1;
        end
    end

    // ***********************************************************************
    // fsm
    // ***********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_state <= IDLE;
        end else begin
            cur_state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = cur_state;
        case (cur_state)
            IDLE: begin
                if (qstruct_valid) nxt_state = DESC_PARSE;
            end
            DESC_PARSE: begin
                if (req_fire & req_last) nxt_state = DRAIN;  // all reads issued
            end
            DRAIN: begin
                // no overlap, next packet waits for the last beat
                if (pyld_last_fire) begin
                    nxt_state = qstruct_valid ? DESC_PARSE : IDLE;
                end
            end
            default: nxt_state = IDLE;
        endcase
    end

endmodule

//--- hdl/st_reg.sv
module st_reg (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                in_valid,
    input  p2p_pkg::p2p_beat_t  in_beat,
    output logic                in_ready,

    output logic                out_valid,
    output p2p_pkg::p2p_beat_t  out_beat,
    input  logic                out_ready
);
    import p2p_pkg::*;

    p2p_beat_t skid_beat;      // holds one beat while output stalls
    logic      out_load;       // main register may take a new beat

    // in_ready low means the skid entry is occupied
    assign out_load = out_ready | ~out_valid;

    // ***********************************************************************
    // control
    // ***********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else if (out_load) begin
            out_valid <= ~in_ready | in_valid;             // skid first, then input
            in_ready  <= 1'b1;                             // skid always empties here
        end else if (in_valid & in_ready) begin
            in_ready  <= 1'b0;                             // beat parked in skid
        end
    end

    // ***********************************************************************
    // payload
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (in_ready) begin
            skid_beat <= in_beat;                          // only kept once in_ready drops
        end
        if (out_load) begin
            out_beat <= in_ready ? in_beat : skid_beat;
        end
    end

endmodule

//--- hdl/p2p_tgt_send_top.sv
module p2p_tgt_send_top (
    input  logic                clk,
    input  logic                rst_n,

    // descriptor channel
    input  logic                desc_valid,
    input  p2p_pkg::p2p_desc_t  desc,
    output logic                desc_ready,

    // block address channel
    input  logic                baddr_valid,
    input  p2p_pkg::buf_addr_t  baddr,
    input  logic                baddr_last,
    output logic                baddr_ready,

    // buffer fill strobe
    input  logic                pbuf_wr_en,
    input  p2p_pkg::pbuf_wr_t   pbuf_wr,

    // downstream p2p channel
    output logic                down_valid,
    output p2p_pkg::p2p_beat_t  down,
    input  logic                down_ready
);
    import p2p_pkg::*;

    logic      qstruct_valid;
    qstruct_t  qstruct;
    logic      qstruct_ready;
    buf_off_t  qstruct_offset;   // send side offset, drives address pop

    logic      pbuf_free_valid;
    pbuf_req_t pbuf_free;
    logic      pbuf_free_ready;

    logic      ft_pyld_valid;
    p2p_beat_t ft_pyld;
    logic      ft_pyld_ready;

    // ***********************************************************************
    // queue, send fsm, buffer, output slice
    // ***********************************************************************
    tgt_qstruct_queue u_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .desc_valid     (desc_valid),
        .desc           (desc),
        .desc_ready     (desc_ready),
        .baddr_valid    (baddr_valid),
        .baddr          (baddr),
        .baddr_last     (baddr_last),
        .baddr_ready    (baddr_ready),
        .qstruct_valid  (qstruct_valid),
        .qstruct        (qstruct),
        .qstruct_ready  (qstruct_ready),
        .qstruct_offset (qstruct_offset)
    );

    tgt_pyld_send_proc u_send (
        .clk             (clk),
        .rst_n           (rst_n),
        .qstruct_valid   (qstruct_valid),
        .qstruct         (qstruct),
        .qstruct_ready   (qstruct_ready),
        .qstruct_offset  (qstruct_offset),
        .pbuf_free_valid (pbuf_free_valid),
        .pbuf_free       (pbuf_free),
        .pbuf_free_ready (pbuf_free_ready),
        .ft_pyld_valid   (ft_pyld_valid),
        .ft_pyld_last    (ft_pyld.last),  // snooped for drain exit
        .ft_pyld_ready   (ft_pyld_ready)
    );

    pyld_buf u_pbuf (
        .clk             (clk),
        .rst_n           (rst_n),
        .pbuf_wr_en      (pbuf_wr_en),
        .pbuf_wr         (pbuf_wr),
        .pbuf_free_valid (pbuf_free_valid),
        .pbuf_free       (pbuf_free),
        .pbuf_free_ready (pbuf_free_ready),
        .ft_pyld_valid   (ft_pyld_valid),
        .ft_pyld         (ft_pyld),
        .ft_pyld_ready   (ft_pyld_ready)
    );

    st_reg u_down_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ft_pyld_valid),
        .in_beat   (ft_pyld),
        .in_ready  (ft_pyld_ready),
        .out_valid (down_valid),
        .out_beat  (down),
        .out_ready (down_ready)
    );

endmodule

//--- verif/tb_p2p_tgt_send.sv
module tb_p2p_tgt_send;
    import p2p_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 16;
    localparam int TOTAL_BEATS = 8 + 22 + 4 * 16 + 63 + 3;     // upper bound over all tests
    localparam int WDOG_CYCLES = 20 * TOTAL_BEATS + 2000;

    logic       clk;
    logic       rst_n;
    logic       desc_valid;
    p2p_desc_t  desc;
    logic       desc_ready;
    logic       baddr_valid;
    buf_addr_t  baddr;
    logic       baddr_last;
    logic       baddr_ready;
    logic       pbuf_wr_en;
    pbuf_wr_t   pbuf_wr;
    logic       down_valid;
    p2p_beat_t  down;
    logic       down_ready;

    beat_data_t  model_mem [256];                   // mirror of the payload buffer
    beat_data_t  exp_data  [$];
    p2p_head_t   exp_head  [$];
    logic        exp_first [$];
    logic        exp_last  [$];
    p2p_desc_t   pend_desc [$];                     // staged packets not yet handed over
    buf_addr_t   pend_blk  [$];
    logic        pend_last [$];
    logic [31:0] data_seed;
    logic [31:0] rdy_seed;
    logic        bp_on;                             // random down_ready when set
    int          blk_base;
    int          blk_idx;

    p2p_tgt_send_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .desc_valid  (desc_valid),
        .desc        (desc),
        .desc_ready  (desc_ready),
        .baddr_valid (baddr_valid),
        .baddr       (baddr),
        .baddr_last  (baddr_last),
        .baddr_ready (baddr_ready),
        .pbuf_wr_en  (pbuf_wr_en),
        .pbuf_wr     (pbuf_wr),
        .down_valid  (down_valid),
        .down        (down),
        .down_ready  (down_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ***********************************************************************
    // random numbers, failure reporting and compare tasks
    // ***********************************************************************
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        data_seed = lcg_step(data_seed);
        return data_seed;
    endfunction

    // odd stride walks all 64 blocks before any repeats
    function automatic buf_addr_t next_block();
        blk_idx = blk_idx + 1;
        return buf_addr_t'(blk_base + blk_idx * 37);
    endfunction

    function automatic p2p_head_t make_head(input dev_num_t ddev, input dev_num_t sdev,
                                            input blen_t blen);
        p2p_head_t h;
        h        = '0;
        h[15:0]  = blen;
        h[39:32] = sdev;
        h[47:40] = ddev;
        return h;
    endfunction

    task automatic report_failure(input string what);
        $display("%s at time %0t", what, $time);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input beat_data_t exp, input beat_data_t got);
        if (got !== exp) begin
            $display("Error: time %0t %s expected %h got %h", $time, name, exp, got);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_head(input string name, input p2p_head_t exp, input p2p_head_t got);
        if (got !== exp) begin
            $display("Error: time %0t %s expected %h got %h", $time, name, exp, got);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error: time %0t %s expected %b got %b", $time, name, exp, got);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // ***********************************************************************
    // drivers
    // ***********************************************************************
    task automatic fill_block(input buf_addr_t blk);
        beat_data_t d;
        for (int o = 0; o < 4; o++) begin
            d = {rand_word(), rand_word()};
            @(negedge clk);
            pbuf_wr_en     = 1'b1;
            pbuf_wr.addr   = blk;
            pbuf_wr.offset = buf_off_t'(o);
            pbuf_wr.data   = d;
            model_mem[int'(blk) * 4 + o] = d;               // block-major index
        end
        @(negedge clk);
        pbuf_wr_en = 1'b0;
    endtask

    task automatic push_desc(input p2p_desc_t d);
        @(negedge clk);
        desc_valid = 1'b1;
        desc       = d;
        while (!desc_ready) @(negedge clk);              // taken on the next rising edge
        @(negedge clk);
        desc_valid = 1'b0;
    endtask

    task automatic push_baddr(input buf_addr_t a, input logic last);
        @(negedge clk);
        baddr_valid = 1'b1;
        baddr       = a;
        baddr_last  = last;
        while (!baddr_ready) @(negedge clk);
        @(negedge clk);
        baddr_valid = 1'b0;
    endtask

    // fills fresh blocks and queues the expected beats of one packet
    task automatic stage_packet(input dev_num_t ddev, input dev_num_t sdev, input blen_t blen);
        buf_addr_t blks [16];
        int        n_beats;
        int        n_blks;
        p2p_desc_t d;
        n_beats = (int'(blen) + 7) / 8;
        n_blks  = (n_beats + 3) / 4;
        for (int b = 0; b < n_blks; b++) begin
            blks[b] = next_block();
            fill_block(blks[b]);
        end
        for (int k = 0; k < n_beats; k++) begin
            exp_data.push_back(model_mem[int'(blks[k / 4]) * 4 + k % 4]);
            exp_head.push_back(make_head(ddev, sdev, blen));
            exp_first.push_back(k == 0);
            exp_last.push_back(k == n_beats - 1);  // offset ((blen-1)/8) mod 4 of the last block
        end
        d.dlid = {16'h0, rand_word()};
        d.ddev = ddev;
        d.sdev = sdev;
        d.blen = blen;
        pend_desc.push_back(d);
        for (int b = 0; b < n_blks; b++) begin
            pend_blk.push_back(blks[b]);
            pend_last.push_back(b == n_blks - 1);
        end
    endtask

    // all descriptors go first so that several wait in the queue together
    task automatic hand_over_packets();
        while (pend_desc.size() != 0) begin
            push_desc(pend_desc.pop_front());
        end
        while (pend_blk.size() != 0) begin
            push_baddr(pend_blk.pop_front(), pend_last.pop_front());
        end
    endtask

    task automatic send_packet(input dev_num_t ddev, input dev_num_t sdev, input blen_t blen);
        stage_packet(ddev, sdev, blen);
        hand_over_packets();
    endtask

    task automatic wait_packets_done(input int max_cycles);
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n = n + 1;
        end
        if (exp_data.size() != 0) begin
            report_failure("packets did not finish on the downstream channel");
        end
        repeat (4) @(negedge clk);
        check_flag("down_valid", 1'b0, down_valid);     // nothing repeated or left over
    endtask

    // ***********************************************************************
    // downstream monitor and ready pattern
    // ***********************************************************************
    always @(posedge clk) begin : down_monitor
        beat_data_t e_data;
        p2p_head_t  e_head;
        logic       e_first;
        logic       e_last;
        if (rst_n && down_valid && down_ready) begin
            if (exp_data.size() == 0) begin
                report_failure("a downstream beat arrived with no packet pending");
            end else begin
                e_data  = exp_data.pop_front();
                e_head  = exp_head.pop_front();
                e_first = exp_first.pop_front();
                e_last  = exp_last.pop_front();
                check_data("down.data", e_data, down.data);
                if (e_first) check_head("down.head", e_head, down.head);
                check_flag("down.last", e_last, down.last);
            end
        end
    end

    always @(negedge clk) begin
        if (bp_on) begin
            rdy_seed   = lcg_step(rdy_seed);
            down_ready = rdy_seed[20] | rdy_seed[27];   // ready about 3 cycles in 4
        end else begin
            down_ready = 1'b1;
        end
    end

    // ***********************************************************************
    // directed tests
    // ***********************************************************************
    task automatic test_reset_levels();
        check_flag("down_valid", 1'b0, down_valid);
        check_flag("desc_ready", 1'b1, desc_ready);
        check_flag("baddr_ready", 1'b1, baddr_ready);
    endtask

    task automatic test_aligned_packet();
        send_packet(8'h21, 8'h05, 16'd64);               // two full blocks
        wait_packets_done(20 * 8 + 100);
    endtask

    task automatic test_odd_lengths();
        blen_t lens [5];
        lens = '{16'd1, 16'd8, 16'd9, 16'd33, 16'd100};
        foreach (lens[i]) begin
            send_packet(dev_num_t'(8'h40 + i), dev_num_t'(8'h10 + i), lens[i]);
            wait_packets_done(20 * 13 + 100);
        end
    endtask

    task automatic test_back_to_back();
        logic [31:0] r;
        for (int p = 0; p < 4; p++) begin
            r = rand_word();
            stage_packet(dev_num_t'(r[31:24]), dev_num_t'(r[23:16]),
                         blen_t'(1 + (r[15:8] % 128)));
        end
        hand_over_packets();                             // four descriptors queued at once
        wait_packets_done(20 * 4 * 16 + 100);
    endtask

    task automatic test_back_pressure();
        bp_on = 1'b1;
        send_packet(8'h7e, 8'h3c, 16'd500);              // 63 beats over 16 blocks
        send_packet(8'h11, 8'h22, 16'd20);
        wait_packets_done(20 * 66 + 100);
        bp_on = 1'b0;
    endtask

    // ***********************************************************************
    // main sequence and watchdog
    // ***********************************************************************
    initial begin
        rst_n       = 1'b0;
        desc_valid  = 1'b0;
        desc        = '0;
        baddr_valid = 1'b0;
        baddr       = '0;
        baddr_last  = 1'b0;
        pbuf_wr_en  = 1'b0;
        pbuf_wr     = '0;
        down_ready  = 1'b1;
        bp_on       = 1'b0;
        data_seed   = 32'd26932;
        rdy_seed    = 32'd26932;
        blk_idx     = 0;
        blk_base    = int'(rand_word() >> 26);
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_levels();
        test_aligned_packet();
        test_odd_lengths();
        test_back_to_back();
        test_back_pressure();
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("run timed out before all tests finished");
        $display(">>> FAIL");
        $fatal(1);
    end

endmodule

//--- sim.f
+incdir+include
hdl/p2p_pkg.sv
hdl/tgt_qstruct_queue.sv
hdl/pyld_buf.sv
hdl/tgt_pyld_send_proc.sv
hdl/st_reg.sv
hdl/p2p_tgt_send_top.sv
verif/tb_p2p_tgt_send.sv

//--- Bender.yml
package:
  name: p2p_tgt_send

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/p2p_pkg.sv
      - hdl/tgt_qstruct_queue.sv
      - hdl/pyld_buf.sv
      - hdl/tgt_pyld_send_proc.sv
      - hdl/st_reg.sv
      - hdl/p2p_tgt_send_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_p2p_tgt_send.sv
